// File: src/lcd_char_overlay.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_char_overlay import lcd_pkg::*; (
    input  logic        sys_clk,
    input  logic        rst_n,
    input  logic        pix_en,
    input  lcd_sync_t   sync,       // From the timing generator
    input  pix_pos_t    pos,
    input  logic [15:0] data_in,    // RGB565 source pixel
    input  logic [23:0] data,       // Value shown as hex
    output lcd_sync_t   ov_sync,    // sync one pixel period later
    output logic [15:0] ov_pixel
);

    logic [23:0] data_q;            // Frame-stable copy of data
    logic        frame_start;
    logic        in_box;
    logic [10:0] box_x;             // Offset inside the digit box
    logic [10:0] box_y;
    logic [2:0]  digit;             // 0 is the leftmost digit
    logic [2:0]  glyph_col;
    logic [2:0]  glyph_row;
    logic [3:0]  nibble;
    logic        font_bit;

    // ------------------------------
    // Box hit and glyph lookup
    // ------------------------------
    assign frame_start = pix_en && sync.vs && !ov_sync.vs;  // Rising vs at input

    assign in_box = sync.de
                 && (pos.x >= CHAR_POS_X) && (pos.x < CHAR_POS_X + CHAR_WIDTH)
                 && (pos.y >= CHAR_POS_Y) && (pos.y < CHAR_POS_Y + CHAR_HEIGHT);

    assign box_x = pos.x - 11'(CHAR_POS_X);
    assign box_y = pos.y - 11'(CHAR_POS_Y);

    assign digit     = 3'(box_x / GLYPH_W);
    assign glyph_col = 3'(box_x % GLYPH_W);
    assign glyph_row = 3'(box_y);

    // Most significant nibble goes to digit 0
    assign nibble   = 4'(data_q >> (4 * (CHAR_DIGITS - 1 - digit)));
    assign font_bit = HEX_FONT[nibble][glyph_row][3'(GLYPH_W - 1) - glyph_col];

    // ------------------------------
    // Pixel stage
    // ------------------------------
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            ov_sync <= '0;
        end else if (pix_en) begin
            ov_sync <= sync;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (frame_start) begin
            data_q <= data;                         // No mixed digits in a frame
        end
        if (pix_en) begin
            if (in_box) begin
                ov_pixel <= font_bit ? BLACK_565 : WHITE_565;
            end else begin
                ov_pixel <= data_in;                // Passthrough
            end
        end
    end

    // Output enable moves only on the pixel strobe
    a_de_on_strobe: assert property (@(posedge sys_clk) disable iff (!rst_n)
        $rose(ov_sync.de) |-> $past(pix_en));

endmodule

`default_nettype wire

// File: src/lcd_id_reader.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_id_reader import lcd_pkg::*; (
    input  logic        sys_clk,
    input  logic        rst_n,
    input  logic [2:0]  id_strap,   // Panel ID strap pins
    output panel_cfg_t  cfg,        // Timing of the detected panel
    output logic        cfg_valid,  // High once the strap is decoded
    output logic        pix_en,     // One sys_clk per pixel period
    output logic [15:0] lcd_id,
    output logic        lcd_pclk
);

    logic [1:0] settle_cnt;         // Delay past reset release
    logic       id_taken;
    logic [1:0] strap_idx;          // Strap folded onto the table
    logic [1:0] panel_idx;
    logic [2:0] div_cnt;            // Position inside the pixel period
    logic       div_last;
    logic [2:0] pclk_half;          // Cycles of pclk high time

    // ------------------------------
    // Strap sampling
    // ------------------------------
    assign strap_idx = id_strap[2] ? 2'd0 : id_strap[1:0];  // Codes 4..7 fall back to 0

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            settle_cnt <= '0;
            id_taken   <= 1'b0;
            panel_idx  <= '0;
            lcd_id     <= '0;
            cfg_valid  <= 1'b0;
        end else begin
            cfg_valid <= id_taken;                  // One cycle after the sample
            if (!id_taken) begin
                if (settle_cnt == 2'(ID_SETTLE - 1)) begin
                    id_taken  <= 1'b1;
                    panel_idx <= strap_idx;
                    lcd_id    <= PANEL_ID[strap_idx];
                end else begin
                    settle_cnt <= settle_cnt + 2'd1;
                end
            end
        end
    end

    assign cfg = PANEL_TABLE[panel_idx];

    // ------------------------------
    // Pixel strobe and pclk
    // ------------------------------
    assign div_last  = (div_cnt == cfg.clk_div - 3'd1);
    assign pclk_half = cfg.clk_div >> 1;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt  <= '0;
            pix_en   <= 1'b0;
            lcd_pclk <= 1'b0;
        end else if (!cfg_valid) begin
            div_cnt  <= '0;                         // Hold divider until decode
            pix_en   <= 1'b0;
            lcd_pclk <= 1'b0;
        end else begin
            div_cnt <= div_last ? 3'd0 : div_cnt + 3'd1;
            pix_en  <= div_last;
            // Divide by 1 cannot toggle, so the strobe itself goes out
            lcd_pclk <= (cfg.clk_div == 3'd1) ? pix_en : (div_cnt < pclk_half);
        end
    end

    // Strobe only starts after the profile is known
    a_pix_en_after_cfg: assert property (@(posedge sys_clk) disable iff (!rst_n)
        $rose(pix_en) |-> $past(cfg_valid));

endmodule

`default_nettype wire

// File: src/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    // ------------------------------
    // Bundled signal types
    // ------------------------------
    typedef struct packed {
        logic hs;                   // Horizontal sync
        logic vs;                   // Vertical sync
        logic de;                   // Data enable
    } lcd_sync_t;

    typedef struct packed {
        logic [10:0] x;             // Active-area column
        logic [10:0] y;             // Active-area row
    } pix_pos_t;

    typedef struct packed {
        logic [10:0] h_disp;        // Visible pixels per line
        logic [10:0] h_sync;
        logic [10:0] h_back;
        logic [10:0] h_total;       // Full line incl. porches
        logic [10:0] v_disp;        // Visible lines per frame
        logic [10:0] v_sync;
        logic [10:0] v_back;
        logic [10:0] v_total;
        logic [2:0]  clk_div;       // sys_clk cycles per pixel
    } panel_cfg_t;

    // ------------------------------
    // Panel timing profiles
    // ------------------------------
    localparam int SYNC_LEN    = 2;  // Same pulse width in both directions
    localparam int BACK_PORCH  = 3;
    localparam int FRONT_PORCH = 2;
    localparam int ID_SETTLE   = 4;  // Strap sampled on this clock after reset

    // Builds one profile from its visible size and pixel divider
    function automatic panel_cfg_t make_cfg(input int width, input int height, input int div);
        panel_cfg_t c;
        c.h_disp  = 11'(width);
        c.h_sync  = 11'(SYNC_LEN);
        c.h_back  = 11'(BACK_PORCH);
        c.h_total = 11'(SYNC_LEN + BACK_PORCH + width + FRONT_PORCH);
        c.v_disp  = 11'(height);
        c.v_sync  = 11'(SYNC_LEN);
        c.v_back  = 11'(BACK_PORCH);
        c.v_total = 11'(SYNC_LEN + BACK_PORCH + height + FRONT_PORCH);
        c.clk_div = 3'(div);
        return c;
    endfunction

    // Indexed by decoded strap, entry 3 mirrors entry 0
    localparam panel_cfg_t PANEL_TABLE [0:3] = '{
        make_cfg(32, 12, 1),
        make_cfg(48, 16, 2),
        make_cfg(64, 20, 4),
        make_cfg(32, 12, 1)
    };

    localparam logic [15:0] PANEL_ID [0:3] = '{
        16'h4342,
        16'h7084,
        16'h1018,
        16'h4342                     // Fallback code
    };

    // ------------------------------
    // Hex overlay geometry
    // ------------------------------
    localparam int CHAR_POS_X  = 1;                      // Box origin column
    localparam int CHAR_POS_Y  = 1;                      // Box origin row
    localparam int CHAR_DIGITS = 6;                      // Nibbles of a 24-bit value
    localparam int GLYPH_W     = 8;
    localparam int GLYPH_H     = 8;
    localparam int CHAR_WIDTH  = CHAR_DIGITS * GLYPH_W;  // 48
    localparam int CHAR_HEIGHT = GLYPH_H;                // 8

    localparam logic [15:0] WHITE_565 = 16'hFFFF;        // Background
    localparam logic [15:0] BLACK_565 = 16'h0000;        // Glyph ink

    // 8x8 glyphs, bit 7 is the leftmost pixel
    localparam logic [7:0] HEX_FONT [0:15][0:7] = '{
        '{8'h3C, 8'h66, 8'h6E, 8'h76, 8'h66, 8'h66, 8'h3C, 8'h00},  // 0
        '{8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7E, 8'h00},  // 1
        '{8'h3C, 8'h66, 8'h06, 8'h0C, 8'h30, 8'h60, 8'h7E, 8'h00},  // 2
        '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h06, 8'h66, 8'h3C, 8'h00},  // 3
        '{8'h0C, 8'h1C, 8'h3C, 8'h6C, 8'h7E, 8'h0C, 8'h0C, 8'h00},  // 4
        '{8'h7E, 8'h60, 8'h7C, 8'h06, 8'h06, 8'h66, 8'h3C, 8'h00},  // 5
        '{8'h3C, 8'h66, 8'h60, 8'h7C, 8'h66, 8'h66, 8'h3C, 8'h00},  // 6
        '{8'h7E, 8'h66, 8'h0C, 8'h18, 8'h18, 8'h18, 8'h18, 8'h00},  // 7
        '{8'h3C, 8'h66, 8'h66, 8'h3C, 8'h66, 8'h66, 8'h3C, 8'h00},  // 8
        '{8'h3C, 8'h66, 8'h66, 8'h3E, 8'h06, 8'h66, 8'h3C, 8'h00},  // 9
        '{8'h18, 8'h3C, 8'h66, 8'h7E, 8'h66, 8'h66, 8'h66, 8'h00},  // A
        '{8'h7C, 8'h66, 8'h66, 8'h7C, 8'h66, 8'h66, 8'h7C, 8'h00},  // B
        '{8'h3C, 8'h66, 8'h60, 8'h60, 8'h60, 8'h66, 8'h3C, 8'h00},  // C
        '{8'h78, 8'h6C, 8'h66, 8'h66, 8'h66, 8'h6C, 8'h78, 8'h00},  // D
        '{8'h7E, 8'h60, 8'h60, 8'h78, 8'h60, 8'h60, 8'h7E, 8'h00},  // E
        '{8'h7E, 8'h60, 8'h60, 8'h78, 8'h60, 8'h60, 8'h60, 8'h00}   // F
    };

endpackage

`default_nettype wire

// File: src/lcd_rgb_out.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_rgb_out import lcd_pkg::*; (
    input  logic        sys_clk,
    input  logic        rst_n,
    input  logic        pix_en,
    input  lcd_sync_t   ov_sync,
    input  logic [15:0] ov_pixel,   // RGB565 after overlay
    input  logic        cfg_valid,
    output logic        lcd_hs,
    output logic        lcd_vs,
    output logic        lcd_de,
    output logic [23:0] lcd_rgb,    // RGB888 pins
    output logic        lcd_bl,     // Backlight
    output logic        lcd_rst     // Panel reset, low while undecoded
);

    logic [23:0] rgb888;
    logic        frame_start;

    // Low bits zero-filled
    assign rgb888 = {ov_pixel[15:11], 3'b000,      // Red 5+3
                     ov_pixel[10:5],  2'b00,       // Green 6+2
                     ov_pixel[4:0],   3'b000};     // Blue 5+3

    assign frame_start = pix_en && ov_sync.vs && !lcd_vs;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            lcd_hs  <= 1'b0;
            lcd_vs  <= 1'b0;
            lcd_de  <= 1'b0;
            lcd_rgb <= '0;
            lcd_bl  <= 1'b0;
            lcd_rst <= 1'b0;
        end else begin
            lcd_rst <= cfg_valid;
            if (!cfg_valid) begin
                lcd_bl <= 1'b0;
            end else if (frame_start) begin
                lcd_bl <= 1'b1;                     // First frame reached the pins
            end
            if (pix_en) begin
                lcd_hs  <= ov_sync.hs;
                lcd_vs  <= ov_sync.vs;
                lcd_de  <= ov_sync.de;
                lcd_rgb <= ov_sync.de ? rgb888 : 24'd0;  // Black in blanking
            end
        end
    end

    // Panel never receives pixels with the backlight still off
    a_bl_before_de: assert property (@(posedge sys_clk) disable iff (!rst_n)
        lcd_de |-> lcd_bl);

endmodule

`default_nettype wire

// File: src/lcd_rgb_top.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_rgb_top import lcd_pkg::*; (
    input  logic        sys_clk,
    input  logic        rst_n,
    input  logic        init_done,
    input  logic [2:0]  id_strap,
    input  logic [23:0] data,       // Shown as six hex digits
    input  logic [15:0] data_in,    // RGB565 source pixel
    output logic        data_req,
    output logic        lcd_hs,
    output logic        lcd_vs,
    output logic        lcd_de,
    output logic [23:0] lcd_rgb,
    output logic        lcd_pclk,
    output logic        lcd_bl,
    output logic        lcd_rst,
    output logic [15:0] lcd_id,
    output logic [10:0] pixel_xpos,
    output logic [10:0] pixel_ypos,
    output logic [10:0] h_disp,
    output logic [10:0] v_disp
);

    panel_cfg_t  cfg;
    logic        cfg_valid;
    logic        pix_en;
    lcd_sync_t   sync;              // Generator timing
    pix_pos_t    pos;
    lcd_sync_t   ov_sync;           // Timing after the overlay stage
    logic [15:0] ov_pixel;

    // ------------------------------
    // Panel detect and pixel strobe
    // ------------------------------
    lcd_id_reader u_id_reader (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .id_strap  (id_strap),
        .cfg       (cfg),
        .cfg_valid (cfg_valid),
        .pix_en    (pix_en),
        .lcd_id    (lcd_id),
        .lcd_pclk  (lcd_pclk)
    );

    lcd_timing_gen u_timing_gen (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .init_done (init_done),
        .cfg       (cfg),
        .cfg_valid (cfg_valid),
        .pix_en    (pix_en),
        .sync      (sync),
        .pos       (pos),
        .data_req  (data_req),
        .h_disp    (h_disp),
        .v_disp    (v_disp)
    );

    assign pixel_xpos = pos.x;
    assign pixel_ypos = pos.y;

    // ------------------------------
    // Pixel path
    // ------------------------------
    lcd_char_overlay u_char_overlay (
        .sys_clk  (sys_clk),
        .rst_n    (rst_n),
        .pix_en   (pix_en),
        .sync     (sync),
        .pos      (pos),
        .data_in  (data_in),
        .data     (data),
        .ov_sync  (ov_sync),
        .ov_pixel (ov_pixel)
    );

    lcd_rgb_out u_rgb_out (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .pix_en    (pix_en),
        .ov_sync   (ov_sync),
        .ov_pixel  (ov_pixel),
        .cfg_valid (cfg_valid),
        .lcd_hs    (lcd_hs),
        .lcd_vs    (lcd_vs),
        .lcd_de    (lcd_de),
        .lcd_rgb   (lcd_rgb),
        .lcd_bl    (lcd_bl),
        .lcd_rst   (lcd_rst)
    );

endmodule

`default_nettype wire

// File: src/lcd_timing_gen.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_timing_gen import lcd_pkg::*; (
    input  logic        sys_clk,
    input  logic        rst_n,
    input  logic        init_done,  // Raster held while low
    input  panel_cfg_t  cfg,
    input  logic        cfg_valid,
    input  logic        pix_en,
    output lcd_sync_t   sync,       // Registered hs/vs/de
    output pix_pos_t    pos,        // Active-area coordinates
    output logic        data_req,   // Source pixel needed this period
    output logic [10:0] h_disp,
    output logic [10:0] v_disp
);

    logic [10:0] h_cnt;             // Pixel within line
    logic [10:0] v_cnt;             // Line within frame
    logic [10:0] h_start;           // First active column count
    logic [10:0] h_end;
    logic [10:0] v_start;
    logic [10:0] v_end;
    logic        run;
    logic        line_end;
    logic        frame_end;
    logic        h_act;
    logic        v_act;

    assign run = init_done && cfg_valid;

    // ------------------------------
    // Window boundaries
    // ------------------------------
    assign h_start = cfg.h_sync + cfg.h_back;
    assign h_end   = h_start + cfg.h_disp;
    assign v_start = cfg.v_sync + cfg.v_back;
    assign v_end   = v_start + cfg.v_disp;

    assign line_end  = (h_cnt == cfg.h_total - 11'd1);
    assign frame_end = (v_cnt == cfg.v_total - 11'd1);

    assign h_act = (h_cnt >= h_start) && (h_cnt < h_end);
    assign v_act = (v_cnt >= v_start) && (v_cnt < v_end);

    // ------------------------------
    // Raster counters
    // ------------------------------
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (!run) begin
            h_cnt <= '0;                            // Restart from frame top
            v_cnt <= '0;
        end else if (pix_en) begin
            if (line_end) begin
                h_cnt <= '0;
                v_cnt <= frame_end ? 11'd0 : v_cnt + 11'd1;
            end else begin
                h_cnt <= h_cnt + 11'd1;
            end
        end
    end

    // Decoded outputs, one pixel period behind the counters
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            sync <= '0;
            pos  <= '0;
        end else if (!run) begin
            sync <= '0;
            pos  <= '0;
        end else if (pix_en) begin
            sync.hs <= (h_cnt < cfg.h_sync);        // Leading part of the line
            sync.vs <= (v_cnt < cfg.v_sync);
            sync.de <= h_act && v_act;
            if (h_act && v_act) begin
                pos.x <= h_cnt - h_start;
                pos.y <= v_cnt - v_start;
            end else begin
                pos <= '0;                          // Zero in blanking
            end
        end
    end

    assign data_req = sync.de;                      // One request per active pixel
    assign h_disp   = cfg.h_disp;
    assign v_disp   = cfg.v_disp;

    // Active window never overlaps the sync pulse
    a_de_not_hs: assert property (@(posedge sys_clk) disable iff (!rst_n)
        !(sync.de && sync.hs));

    a_pos_x_range: assert property (@(posedge sys_clk) disable iff (!rst_n)
        sync.de |-> (pos.x < cfg.h_disp));

endmodule

`default_nettype wire

// File: tb.f
src/lcd_pkg.sv
src/lcd_id_reader.sv
src/lcd_timing_gen.sv
src/lcd_char_overlay.sv
src/lcd_rgb_out.sv
src/lcd_rgb_top.sv
tb/tb_lcd_rgb_top.sv

// File: tb/tb_lcd_rgb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lcd_rgb_top import lcd_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DLY    = 2;    // Input skew after the rising edge
    localparam int RESET_CYCLES = 10;
    localparam int INIT_HOLD    = 16;   // Cycles of init_done low after decode
    localparam int FRAMES       = 2;

    // Expected panel profile for each strap code under test
    localparam int SYNC_W  = 2;
    localparam int PORCH_B = 3;
    localparam int PORCH_F = 2;
    localparam int RUN_W   [0:2] = '{32, 48, 64};
    localparam int RUN_H   [0:2] = '{12, 16, 20};
    localparam int RUN_DIV [0:2] = '{1, 2, 4};
    localparam logic [15:0] RUN_ID [0:2] = '{16'h4342, 16'h7084, 16'h1018};

    logic        sys_clk;
    logic        rst_n;
    logic        init_done;
    logic [2:0]  id_strap;
    logic [23:0] data;
    logic [15:0] data_in;
    logic        data_req;
    logic        lcd_hs;
    logic        lcd_vs;
    logic        lcd_de;
    logic [23:0] lcd_rgb;
    logic        lcd_pclk;
    logic        lcd_bl;
    logic        lcd_rst;
    logic [15:0] lcd_id;
    logic [10:0] pixel_xpos;
    logic [10:0] pixel_ypos;
    logic [10:0] h_disp;
    logic [10:0] v_disp;

    // Model state
    logic [31:0] rng;
    logic [15:0] src_q [$];           // Requested pixels not yet on the pins
    logic        running;
    logic [23:0] shown_data;          // Value on screen this frame
    int          w;
    int          h;
    int          div;
    int          ht;
    int          vt;
    int          cyc;
    int          total_cyc;
    int          limit;
    logic        req_prev;
    logic        de_prev;
    logic        hs_prev;
    logic        vs_prev;
    logic        pclk_prev;
    int          req_phase;           // sys_clk within the pixel period
    int          de_phase;
    int          req_x;               // Active coordinates of the next request
    int          req_y;
    int          pix_x;
    int          line_cnt;
    int          hs_rises;
    int          vs_rises;
    int          vs_len;
    int          pclk_last;
    int          req_total;
    int          de_total;

    lcd_rgb_top i_dut (.*);

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Zero-filled 565 to 888
    function automatic logic [23:0] rgb565_to_888(input logic [15:0] p);
        return {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
    endfunction

    // Glyph colour inside the digit box, source pixel elsewhere
    function automatic logic [15:0] overlay_pixel(input int x, input int y,
                                                  input logic [23:0] val,
                                                  input logic [15:0] src);
        int         d;
        logic [3:0] nib;
        if (x < CHAR_POS_X || x >= CHAR_POS_X + CHAR_WIDTH ||
            y < CHAR_POS_Y || y >= CHAR_POS_Y + CHAR_HEIGHT) begin
            return src;
        end
        d   = (x - CHAR_POS_X) / GLYPH_W;
        nib = val[4 * (CHAR_DIGITS - 1 - d) +: 4];   // Digit 0 is the top nibble
        if (HEX_FONT[nib][y - CHAR_POS_Y][GLYPH_W - 1 - ((x - CHAR_POS_X) % GLYPH_W)]) begin
            return BLACK_565;
        end
        return WHITE_565;
    endfunction

    // Three frames of every profile plus margin for reset and decode
    function automatic int timeout_cycles();
        int sum;
        sum = 200;
        for (int i = 0; i < 3; i++) begin
            sum += 3 * (SYNC_W + PORCH_B + RUN_W[i] + PORCH_F)
                     * (SYNC_W + PORCH_B + RUN_H[i] + PORCH_F) * RUN_DIV[i];
        end
        return sum;
    endfunction

    // ------------------------------
    // Per-cycle checks
    // ------------------------------
    task automatic check_idle_outputs();
        assert (!lcd_de && !data_req && !lcd_bl) else begin
            $display("Panel outputs active while in reset or before init_done");
            stop_with_failure();
        end
        assert (lcd_rgb == 24'h0) else begin
            $display("MISMATCH lcd_rgb: got %h expected %h", lcd_rgb, 24'h0);
            stop_with_failure();
        end
    endtask

    task automatic check_sink();
        logic [15:0] src;
        logic [23:0] exp_rgb;
        assert (!(lcd_de && (lcd_hs || lcd_vs))) else begin
            $display("lcd_de high during a sync pulse");
            stop_with_failure();
        end
        if (lcd_vs && !vs_prev) begin            // Frame start on the pins
            if (vs_rises > 0) begin
                assert (hs_rises == vt) else begin
                    $display("MISMATCH lcd_hs pulses per frame: got %h expected %h",
                             hs_rises, vt);
                    stop_with_failure();
                end
                assert (line_cnt == h) else begin
                    $display("MISMATCH lcd_de lines per frame: got %h expected %h",
                             line_cnt, h);
                    stop_with_failure();
                end
            end
            vs_rises++;
            hs_rises   = 0;
            line_cnt   = 0;
            vs_len     = 0;
            shown_data = data;                     // Held since the last vs fall
        end
        if (lcd_hs && !hs_prev) hs_rises++;
        if (lcd_vs) vs_len++;
        if (!lcd_vs && vs_prev) begin
            assert (vs_len == SYNC_W * ht * div) else begin
                $display("MISMATCH lcd_vs width: got %h expected %h",
                         vs_len, SYNC_W * ht * div);
                stop_with_failure();
            end
            rng  = xorshift32(rng);
            data = rng[23:0];                      // New value well before next frame
        end
        if (lcd_de && (!de_prev || de_phase == div - 1)) begin
            de_phase = 0;
            assert (lcd_bl) else begin
                $display("Backlight off during an active pixel");
                stop_with_failure();
            end
            assert (src_q.size() > 0) else begin
                $display("Active pixel on the panel without a requested source pixel");
                stop_with_failure();
            end
            src     = src_q.pop_front();          // Popped even under the box
            exp_rgb = rgb565_to_888(overlay_pixel(pix_x, line_cnt, shown_data, src));
            assert (lcd_rgb == exp_rgb) else begin
                $display("MISMATCH lcd_rgb at x=%0d y=%0d: got %h expected %h",
                         pix_x, line_cnt, lcd_rgb, exp_rgb);
                stop_with_failure();
            end
            pix_x++;
            de_total++;
        end else if (lcd_de) begin
            de_phase++;
        end else begin
            assert (lcd_rgb == 24'h0) else begin
                $display("MISMATCH lcd_rgb: got %h expected %h", lcd_rgb, 24'h0);
                stop_with_failure();
            end
        end
        if (!lcd_de && de_prev) begin             // Line done
            assert (pix_x == w) else begin
                $display("MISMATCH lcd_de pixels per line: got %h expected %h", pix_x, w);
                stop_with_failure();
            end
            pix_x = 0;
            line_cnt++;
        end
        // Pixel clock
        if (div == 1) begin
            assert (lcd_pclk) else begin
                $display("lcd_pclk not held high with a divider of 1");
                stop_with_failure();
            end
        end else if (lcd_pclk && !pclk_prev) begin
            if (pclk_last >= 0) begin
                assert (cyc - pclk_last == div) else begin
                    $display("MISMATCH lcd_pclk period: got %h expected %h",
                             cyc - pclk_last, div);
                    stop_with_failure();
                end
            end
            pclk_last = cyc;
        end
        hs_prev   = lcd_hs;
        vs_prev   = lcd_vs;
        de_prev   = lcd_de;
        pclk_prev = lcd_pclk;
    endtask

    // Upstream source with one fresh pixel per requested period
    task automatic drive_source();
        if (data_req && (!req_prev || req_phase == div - 1)) begin
            req_phase = 0;
            assert (pixel_xpos == req_x && pixel_ypos == req_y) else begin
                $display("MISMATCH pixel_xpos/pixel_ypos: got %h/%h expected %h/%h",
                         pixel_xpos, pixel_ypos, req_x, req_y);
                stop_with_failure();
            end
            rng       = xorshift32(rng);
            data_in   = rng[15:0];
            src_q.push_back(rng[15:0]);
            req_total++;
            req_x++;
            if (req_x == w) begin                 // Raster order, wraps per frame
                req_x = 0;
                req_y = (req_y == h - 1) ? 0 : req_y + 1;
            end
        end else if (data_req) begin
            req_phase++;
        end else begin
            assert (pixel_xpos == 11'd0 && pixel_ypos == 11'd0) else begin
                $display("MISMATCH pixel_xpos/pixel_ypos: got %h/%h expected %h/%h",
                         pixel_xpos, pixel_ypos, 11'd0, 11'd0);
                stop_with_failure();
            end
            rng     = xorshift32(rng);
            data_in = rng[31:16];                  // Junk between requests
        end
        req_prev = data_req;
    endtask

    task automatic tick();
        @(posedge sys_clk);
        #DRIVE_DLY;
        cyc++;
        if (!rst_n || !init_done) check_idle_outputs();
        if (running) begin
            check_sink();
            drive_source();
        end
    endtask

    // ------------------------------
    // One strap code, two frames
    // ------------------------------
    task automatic run_panel(input int idx);
        w         = RUN_W[idx];
        h         = RUN_H[idx];
        div       = RUN_DIV[idx];
        ht        = SYNC_W + PORCH_B + w + PORCH_F;
        vt        = SYNC_W + PORCH_B + h + PORCH_F;
        rst_n     = 1'b0;
        init_done = 1'b0;
        id_strap  = 3'(idx);
        repeat (RESET_CYCLES) tick();
        rst_n = 1'b1;
        while (!lcd_rst) tick();                 // Watchdog covers a stuck decode
        assert (lcd_id == RUN_ID[idx]) else begin
            $display("MISMATCH lcd_id: got %h expected %h", lcd_id, RUN_ID[idx]);
            stop_with_failure();
        end
        assert (h_disp == w && v_disp == h) else begin
            $display("MISMATCH h_disp/v_disp: got %h/%h expected %h/%h",
                     h_disp, v_disp, w, h);
            stop_with_failure();
        end
        repeat (INIT_HOLD) tick();
        req_prev  = 1'b0;
        de_prev   = 1'b0;
        hs_prev   = 1'b0;
        vs_prev   = 1'b0;
        pclk_prev = lcd_pclk;
        req_phase = 0;
        de_phase  = 0;
        req_x     = 0;
        req_y     = 0;
        pix_x     = 0;
        line_cnt  = 0;
        hs_rises  = 0;
        vs_rises  = 0;
        vs_len    = 0;
        pclk_last = -1;
        req_total = 0;
        de_total  = 0;
        src_q.delete();
        rng       = xorshift32(rng);
        data      = rng[23:0];
        init_done = 1'b1;
        running   = 1'b1;
        while (vs_rises < FRAMES + 1) tick();   // Stop at the start of frame 3
        running = 1'b0;
        assert (req_total == de_total && de_total == FRAMES * w * h) else begin
            $display("MISMATCH data_req count: got %h expected %h (lcd_de pixels %h)",
                     req_total, FRAMES * w * h, de_total);
            stop_with_failure();
        end
        assert (src_q.size() == 0) else begin
            $display("Requested source pixels never reached the panel");
            stop_with_failure();
        end
    endtask

    // Watchdog
    always @(posedge sys_clk) begin
        total_cyc = total_cyc + 1;
        if (total_cyc > limit) begin
            $display("Timeout after %0d cycles without finishing the panel runs", limit);
            stop_with_failure();
        end
    end

    initial begin
        rst_n     = 1'b0;
        init_done = 1'b0;
        id_strap  = 3'd0;
        data      = '0;
        data_in   = '0;
        running   = 1'b0;
        cyc       = 0;
        total_cyc = 0;
        rng       = 32'd53925;
        limit     = timeout_cycles();
        for (int i = 0; i < 3; i++) begin
            run_panel(i);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
